// ==== logic/leaf_pkg.sv ====
package leaf_pkg;

    // packet field widths
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;
    localparam int PAYLOAD_BITS = 32;

    // valid bit plus the four fields
    localparam int PACKET_BITS = 1 + LEAF_BITS + PORT_BITS + ADDR_BITS + PAYLOAD_BITS;

    // ports 0 and 1 are configuration, input ports start at 2, output ports at 9
    localparam int FIRST_IN_PORT  = 2;
    localparam int FIRST_OUT_PORT = 9;

    // network packet, msb first
    typedef struct packed {
        logic                    valid;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } bft_packet_t;

    // what the decoder made of an incoming packet
    typedef enum logic [1:0] {
        PKT_DROP,
        PKT_CONFIG,
        PKT_IN_DATA
    } packet_kind_e;

    // transmit side toward the network
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SENT,
        TX_HOLD
    } tx_state_e;

endpackage

// ==== logic/packet_if.sv ====
`timescale 1ns/10ps

interface packet_if
    import leaf_pkg::*;
();

    // registered copy of the network packet
    bft_packet_t          pkt;
    packet_kind_e         kind;
    // input port number relative to FIRST_IN_PORT
    logic [PORT_BITS-1:0] in_index;
    // one cycle per decoded packet that is not dropped
    logic                 strobe;

    modport source (
        output pkt,
        output kind,
        output in_index,
        output strobe
    );

    modport sink (
        input pkt,
        input kind,
        input in_index,
        input strobe
    );

endinterface

// ==== logic/packet_decoder.sv ====
`timescale 1ns/10ps

module packet_decoder
    import leaf_pkg::*;
#(
    parameter int NUM_IN_PORTS = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  bft_packet_t din_bft,
    packet_if.source    dec
);

    packet_kind_e         kind_next;
    logic [PORT_BITS-1:0] index_next;
    logic                 in_range;

    // input ports occupy FIRST_IN_PORT up to the configured count,
    // never reaching into the output port range
    always_comb begin
        in_range = (int'(din_bft.port) >= FIRST_IN_PORT)
                && (int'(din_bft.port) < FIRST_IN_PORT + NUM_IN_PORTS)
                && (int'(din_bft.port) < FIRST_OUT_PORT);
        index_next = din_bft.port - PORT_BITS'(FIRST_IN_PORT);

        if (!din_bft.valid) begin
            kind_next = PKT_DROP;
        end else if (int'(din_bft.port) < FIRST_IN_PORT) begin
            // ports 0 and 1 carry table writes
            kind_next = PKT_CONFIG;
        end else if (in_range) begin
            kind_next = PKT_IN_DATA;
        end else begin
            // output ports and unused input ports
            kind_next = PKT_DROP;
        end
    end

    // packet fields only mean something while strobe is high
    always_ff @(posedge clk) begin
        dec.pkt      <= din_bft;
        dec.kind     <= kind_next;
        dec.in_index <= index_next;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.strobe <= 1'b0;
        end else begin
            dec.strobe <= (kind_next != PKT_DROP);
        end
    end

endmodule

// ==== logic/port_config_table.sv ====
`timescale 1ns/10ps

module port_config_table
    import leaf_pkg::*;
#(
    parameter int NUM_OUT_PORTS = 2
) (
    input  logic                                    clk,
    input  logic                                    reset,
    packet_if.sink                                  dec,
    output logic [NUM_OUT_PORTS-1:0][LEAF_BITS-1:0] dest_leaf,
    output logic [NUM_OUT_PORTS-1:0][PORT_BITS-1:0] dest_port
);

    logic                 cfg_write;
    logic [LEAF_BITS-1:0] cfg_leaf;
    logic [PORT_BITS-1:0] cfg_port;

    // payload layout of a configuration packet: leaf in the low bits, port above it
    always_comb begin
        cfg_write = dec.strobe && (dec.kind == PKT_CONFIG);
        cfg_leaf  = dec.pkt.payload[LEAF_BITS-1:0];
        cfg_port  = dec.pkt.payload[LEAF_BITS +: PORT_BITS];
    end

    // addr picks the output port; an index with no matching entry writes nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            dest_leaf <= '0;
            dest_port <= '0;
        end else if (cfg_write) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (dec.pkt.addr == ADDR_BITS'(i)) begin
                    dest_leaf[i] <= cfg_leaf;
                    dest_port[i] <= cfg_port;
                end
            end
        end
    end

endmodule

// ==== logic/stream_flow_control.sv ====
`timescale 1ns/10ps

module stream_flow_control
    import leaf_pkg::*;
#(
    parameter int NUM_IN_PORTS  = 1,
    parameter int NUM_OUT_PORTS = 2,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                                       clk,
    input  logic                                       reset,
    packet_if.sink                                     dec,
    input  logic [NUM_OUT_PORTS-1:0][LEAF_BITS-1:0]    dest_leaf,
    input  logic [NUM_OUT_PORTS-1:0][PORT_BITS-1:0]    dest_port,
    output logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  data_to_user,
    output logic [NUM_IN_PORTS-1:0]                    vld_to_user,
    input  logic [NUM_IN_PORTS-1:0]                    ack_from_user,
    input  logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] data_from_user,
    input  logic [NUM_OUT_PORTS-1:0]                   vld_from_user,
    output logic [NUM_OUT_PORTS-1:0]                   ack_to_user,
    output bft_packet_t                                dout_bft,
    input  logic                                       resend,
    output logic [7:0]                                 drop_count
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [PAYLOAD_BITS-1:0] fifo_mem [NUM_IN_PORTS][FIFO_DEPTH];
    logic [PTR_BITS-1:0]     wr_ptr [NUM_IN_PORTS];
    logic [PTR_BITS-1:0]     rd_ptr [NUM_IN_PORTS];
    logic [CNT_BITS-1:0]     fill [NUM_IN_PORTS];
    logic [NUM_IN_PORTS-1:0] push;
    logic [NUM_IN_PORTS-1:0] full;
    logic [NUM_IN_PORTS-1:0] wr_en;
    logic [NUM_IN_PORTS-1:0] pop;
    logic                    drop;

    tx_state_e                tx_state;
    logic [ADDR_BITS-1:0]     seq_num [NUM_OUT_PORTS];
    logic [NUM_OUT_PORTS-1:0] eligible;
    logic [NUM_OUT_PORTS-1:0] grant;
    bft_packet_t              tx_pkt;
    bft_packet_t              last_pkt;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // receive side, one FIFO per input port
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            push[i]         = dec.strobe && (dec.kind == PKT_IN_DATA)
                           && (dec.in_index == PORT_BITS'(i));
            full[i]         = (fill[i] == CNT_BITS'(FIFO_DEPTH));
            wr_en[i]        = push[i] && !full[i];
            vld_to_user[i]  = (fill[i] != '0);
            pop[i]          = vld_to_user[i] && ack_from_user[i];
            data_to_user[i] = fifo_mem[i][rd_ptr[i]];
        end
        // a full FIFO loses the packet even if the user pops this cycle
        drop = |(push & full);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            if (wr_en[i]) begin
                fifo_mem[i][wr_ptr[i]] <= dec.pkt.payload;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                fill[i]   <= '0;
            end
            drop_count <= '0;
        end else begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                if (wr_en[i]) begin
                    wr_ptr[i] <= next_ptr(wr_ptr[i]);
                end
                if (pop[i]) begin
                    rd_ptr[i] <= next_ptr(rd_ptr[i]);
                end
                if (wr_en[i] && !pop[i]) begin
                    fill[i] <= fill[i] + 1'b1;
                end else if (pop[i] && !wr_en[i]) begin
                    fill[i] <= fill[i] - 1'b1;
                end
            end
            // saturates rather than wrapping
            if (drop && (drop_count != 8'hff)) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // transmit side; the port acked last cycle already gave its word
    always_comb begin
        eligible = vld_from_user;
        if (tx_state == TX_SENT) begin
            eligible = vld_from_user & ~ack_to_user;
        end
        // lowest set bit wins
        grant = eligible & (~eligible + 1'b1);

        tx_pkt       = '0;
        tx_pkt.valid = 1'b1;
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            if (grant[j]) begin
                tx_pkt.leaf    = dest_leaf[j];
                tx_pkt.port    = dest_port[j];
                tx_pkt.addr    = seq_num[j];
                tx_pkt.payload = data_from_user[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_state    <= TX_IDLE;
            dout_bft    <= '0;
            last_pkt    <= '0;
            ack_to_user <= '0;
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                seq_num[j] <= '0;
            end
        end else if (resend) begin
            // network back-pressure, repeat and hold off the user
            tx_state    <= TX_HOLD;
            dout_bft    <= last_pkt;
            ack_to_user <= '0;
        end else if (|grant) begin
            tx_state    <= TX_SENT;
            dout_bft    <= tx_pkt;
            last_pkt    <= tx_pkt;
            ack_to_user <= grant;
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                if (grant[j]) begin
                    seq_num[j] <= seq_num[j] + 1'b1;
                end
            end
        end else begin
            tx_state    <= TX_IDLE;
            dout_bft    <= '0;
            ack_to_user <= '0;
        end
    end

endmodule

// ==== logic/leaf_interface.sv ====
`timescale 1ns/10ps

module leaf_interface
    import leaf_pkg::*;
#(
    parameter int NUM_IN_PORTS  = 1,
    parameter int NUM_OUT_PORTS = 2,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                                       clk,
    input  logic                                       reset,
    // network side
    input  logic [PACKET_BITS-1:0]                     din_bft,
    output logic [PACKET_BITS-1:0]                     dout_bft,
    input  logic                                       resend,
    // toward the user
    output logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  data_to_user,
    output logic [NUM_IN_PORTS-1:0]                    vld_to_user,
    input  logic [NUM_IN_PORTS-1:0]                    ack_from_user,
    // from the user
    input  logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] data_from_user,
    input  logic [NUM_OUT_PORTS-1:0]                   vld_from_user,
    output logic [NUM_OUT_PORTS-1:0]                   ack_to_user,
    output logic [7:0]                                 drop_count
);

    packet_if dec_if ();

    logic [NUM_OUT_PORTS-1:0][LEAF_BITS-1:0] dest_leaf;
    logic [NUM_OUT_PORTS-1:0][PORT_BITS-1:0] dest_port;

    packet_decoder #(
        .NUM_IN_PORTS (NUM_IN_PORTS)
    ) i_packet_decoder (
        .clk     (clk),
        .reset   (reset),
        .din_bft (din_bft),
        .dec     (dec_if.source)
    );

    port_config_table #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) i_port_config_table (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec_if.sink),
        .dest_leaf (dest_leaf),
        .dest_port (dest_port)
    );

    stream_flow_control #(
        .NUM_IN_PORTS  (NUM_IN_PORTS),
        .NUM_OUT_PORTS (NUM_OUT_PORTS),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) i_stream_flow_control (
        .clk            (clk),
        .reset          (reset),
        .dec            (dec_if.sink),
        .dest_leaf      (dest_leaf),
        .dest_port      (dest_port),
        .data_to_user   (data_to_user),
        .vld_to_user    (vld_to_user),
        .ack_from_user  (ack_from_user),
        .data_from_user (data_from_user),
        .vld_from_user  (vld_from_user),
        .ack_to_user    (ack_to_user),
        .dout_bft       (dout_bft),
        .resend         (resend),
        .drop_count     (drop_count)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam real HALF_PERIOD = 5.0;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset spans the first two rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== tests/leaf_interface_tb.sv ====
`timescale 1ns/10ps

module leaf_interface_tb
    import leaf_pkg::*;
();

    localparam int NUM_IN  = 2;
    localparam int NUM_OUT = 2;
    localparam int DEPTH   = 4;

    logic                                 clk;
    logic                                 reset;
    bft_packet_t                          din_bft;
    bft_packet_t                          dout_bft;
    logic                                 resend;
    logic [NUM_IN-1:0][PAYLOAD_BITS-1:0]  data_to_user;
    logic [NUM_IN-1:0]                    vld_to_user;
    logic [NUM_IN-1:0]                    ack_from_user;
    logic [NUM_OUT-1:0][PAYLOAD_BITS-1:0] data_from_user;
    logic [NUM_OUT-1:0]                   vld_from_user;
    logic [NUM_OUT-1:0]                   ack_to_user;
    logic [7:0]                           drop_count;

    // stimulus lines as read from the file
    int          op_test [$];
    logic [7:0]  op_code [$];
    logic [31:0] op_a [$];
    logic [31:0] op_b [$];
    logic [31:0] op_c [$];
    int          num_ops = 0;

    // reference model of the destination table, sequence numbers and input FIFOs
    logic [LEAF_BITS-1:0]    tbl_leaf [NUM_OUT];
    logic [PORT_BITS-1:0]    tbl_port [NUM_OUT];
    logic [ADDR_BITS-1:0]    seq_exp [NUM_OUT];
    logic [PAYLOAD_BITS-1:0] fifo_exp [NUM_IN][$];
    bft_packet_t             last_sent;

    int checks = 0;
    int errors = 0;

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    leaf_interface #(
        .NUM_IN_PORTS  (NUM_IN),
        .NUM_OUT_PORTS (NUM_OUT),
        .FIFO_DEPTH    (DEPTH)
    ) i_leaf_interface (
        .clk            (clk),
        .reset          (reset),
        .din_bft        (din_bft),
        .dout_bft       (dout_bft),
        .resend         (resend),
        .data_to_user   (data_to_user),
        .vld_to_user    (vld_to_user),
        .ack_from_user  (ack_from_user),
        .data_from_user (data_from_user),
        .vld_from_user  (vld_from_user),
        .ack_to_user    (ack_to_user),
        .drop_count     (drop_count)
    );

    task automatic check(input logic [63:0] got, input logic [63:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          n;
        int          t;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        string       line;
        fd = $fopen("tests/leaf_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                a = '0;
                b = '0;
                c = '0;
                // comment lines start with '#'
                if ($fgets(line, fd) != 0 && line.len() > 2 && line[0] != "#") begin
                    n = $sscanf(line, "%d %c %h %h %h", t, op, a, b, c);
                    if (n >= 2) begin
                        op_test.push_back(t);
                        op_code.push_back(op);
                        op_a.push_back(a);
                        op_b.push_back(b);
                        op_c.push_back(c);
                    end
                end
            end
            $fclose(fd);
            num_ops = op_test.size();
        end
    endtask

    // one network packet for a single cycle; returns on the next falling edge
    task automatic send_packet(input logic [PORT_BITS-1:0] port,
                               input logic [ADDR_BITS-1:0] addr,
                               input logic [PAYLOAD_BITS-1:0] payload);
        din_bft.valid   = 1'b1;
        din_bft.leaf    = 5'd1;
        din_bft.port    = port;
        din_bft.addr    = addr;
        din_bft.payload = payload;
        @(negedge clk);
        din_bft = '0;
    endtask

    // the user holds each word until the edge that closes its ack cycle
    task automatic send_user_words(input logic [1:0] mask, input logic [31:0] w0,
                                   input logic [31:0] w1);
        bft_packet_t        expected;
        int                 waited;
        logic [NUM_OUT-1:0] taken;
        taken = '0;
        for (int j = 0; j < NUM_OUT; j++) begin
            vld_from_user[j]  = mask[j];
            data_from_user[j] = (j == 0) ? w0 : w1;
        end
        // words wait while the network holds resend
        if (resend) begin
            repeat (3) begin
                @(negedge clk);
                check(dout_bft, last_sent, "dout_bft during resend");
                check(ack_to_user, 0, "ack_to_user during resend");
            end
            resend = 1'b0;
        end
        for (int j = 0; j < NUM_OUT; j++) begin
            if (mask[j]) begin
                waited = 0;
                while (!ack_to_user[j] && waited < 10) begin
                    @(negedge clk);
                    waited++;
                    // words acked one cycle earlier were taken at the edge just passed
                    vld_from_user = vld_from_user & ~taken;
                    taken         = '0;
                end
                if (!ack_to_user[j]) begin
                    errors++;
                    $display("user output port %0d was never acknowledged", j);
                end else begin
                    expected = {1'b1, tbl_leaf[j], tbl_port[j], seq_exp[j], data_from_user[j]};
                    check(waited, 1, "cycles from vld_from_user to ack_to_user");
                    check(dout_bft, expected, "dout_bft packet");
                    check(ack_to_user, 1 << j, "ack_to_user");
                    seq_exp[j]++;
                    last_sent = expected;
                    taken[j]  = 1'b1;
                end
            end
        end
        // the last word is taken at the next edge without a second packet or ack
        @(negedge clk);
        check(ack_to_user, 0, "ack_to_user after the last word was taken");
        check(dout_bft.valid, 0, "dout_bft valid after the last word was taken");
        vld_from_user = '0;
    endtask

    initial begin
        bit          ok;
        int          cur_test;
        int          errors_before;
        int          lane;
        bit          was_empty;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;

        din_bft        = '0;
        resend         = 1'b0;
        ack_from_user  = '0;
        data_from_user = '0;
        vld_from_user  = '0;
        void'($urandom(32'h87a7));
        for (int j = 0; j < NUM_OUT; j++) begin
            tbl_leaf[j] = '0;
            tbl_port[j] = '0;
            seq_exp[j]  = '0;
        end
        last_sent     = '0;
        cur_test      = -1;
        errors_before = 0;
        load_stimulus(ok);
        if (!ok) begin
            $display("could not open the stimulus file tests/leaf_stim.txt");
            $display("Checks failed");
            $finish;
        end else begin
            @(negedge reset);
            for (int k = 0; k < num_ops; k++) begin
                if (op_test[k] != cur_test) begin
                    if (cur_test >= 0) begin
                        $display("test %0d finished with %0d errors", cur_test,
                                 errors - errors_before);
                    end
                    cur_test      = op_test[k];
                    errors_before = errors;
                end
                op = op_code[k];
                a  = op_a[k];
                b  = op_b[k];
                c  = op_c[k];
                repeat ($urandom % 4) @(negedge clk);
                case (op)
                    "I": begin
                        repeat (a) begin
                            @(negedge clk);
                            check(vld_to_user, 0, "vld_to_user while idle");
                            check(ack_to_user, 0, "ack_to_user while idle");
                            check(dout_bft.valid, 0, "dout_bft valid while idle");
                        end
                    end
                    "C": begin
                        // payload holds the port above the leaf
                        send_packet(PORT_BITS'(a[0]), ADDR_BITS'(a), {23'd0, c[3:0], b[4:0]});
                        @(negedge clk);
                        if (a < NUM_OUT) begin
                            tbl_leaf[a] = b[4:0];
                            tbl_port[a] = c[3:0];
                        end
                    end
                    "N": begin
                        lane = int'(a) - FIRST_IN_PORT;
                        send_packet(a[3:0], 7'd0, b);
                        if (lane >= 0 && lane < NUM_IN) begin
                            was_empty = (fifo_exp[lane].size() == 0);
                            if (was_empty) begin
                                check(vld_to_user[lane], 0, "vld_to_user 1 cycle after packet");
                            end
                            @(negedge clk);
                            if (was_empty) begin
                                check(vld_to_user[lane], 1, "vld_to_user 2 cycles after packet");
                            end
                            if (fifo_exp[lane].size() < DEPTH) begin
                                fifo_exp[lane].push_back(b);
                            end
                        end
                    end
                    "A": begin
                        lane = int'(a);
                        if (fifo_exp[lane].size() == 0) begin
                            check(vld_to_user[lane], 0, "vld_to_user with an empty FIFO");
                        end else begin
                            check(vld_to_user[lane], 1, "vld_to_user with data queued");
                            check(data_to_user[lane], fifo_exp[lane].pop_front(), "data_to_user");
                            ack_from_user[lane] = 1'b1;
                            @(negedge clk);
                            ack_from_user[lane] = 1'b0;
                        end
                    end
                    "S": begin
                        resend = a[0];
                        @(negedge clk);
                        if (resend) begin
                            check(dout_bft, last_sent, "dout_bft repeat on resend");
                        end
                    end
                    "U": send_user_words(a[1:0], b, c);
                    "E": check(drop_count, a[7:0], "drop_count");
                    default: begin
                        errors++;
                        $display("unknown operation %c in stimulus entry %0d", op, k + 1);
                    end
                endcase
            end
            if (cur_test >= 0) begin
                $display("test %0d finished with %0d errors", cur_test, errors - errors_before);
            end
            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // 40 clock cycles of 10 ns for every stimulus line
    initial begin
        wait (num_ops > 0);
        #(num_ops * 40 * 10);
        $display("the run timed out after %0d stimulus lines", num_ops);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/leaf_pkg.sv
logic/packet_if.sv
logic/packet_decoder.sv
logic/port_config_table.sv
logic/stream_flow_control.sv
logic/leaf_interface.sv
tests/tb_clock.sv
tests/leaf_interface_tb.sv

// ==== Makefile ====
# Verilator build and run of the leaf interface testbench

VERILATOR ?= verilator
TOP       ?= leaf_interface_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: run clean

# the run passes only if the log holds the pass message
run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/leaf_stim.txt ====
# test op operands (hex): I cycles | C index leaf port | N port payload | A lane
# U mask word0 word1 | S resend | E drop_count
1 I 6
2 C 0 0a 3
2 C 1 15 c
2 C 5 1f f
2 U 1 cafe0001 0
2 U 2 0 beef0001
2 U 1 cafe0002 0
2 U 2 0 beef0002
2 U 1 cafe0003 0
2 U 2 0 beef0003
3 N 2 11111111
3 N 3 33333333
3 N 2 22222222
3 A 0
3 A 1
3 A 0
3 I 3
4 N 2 40000001
4 N 2 40000002
4 N 2 40000003
4 N 2 40000004
4 N 2 40000005
4 E 1
4 A 0
4 A 0
4 A 0
4 A 0
4 A 0
4 N 9 90000000
4 N 4 44444444
4 N f ffffffff
4 I 4
4 E 1
5 S 1
5 U 1 d00d0001 0
6 U 3 a0a0a0a0 b1b1b1b1
6 I 3
